// File: common/cpu_isa_pkg.sv
// ISA constants for 16-bit words; opcodes 5-7, A, B and E are unassigned and decode as NOP
package cpu_isa_pkg;

   // Word and field widths fixed by the ISA
   localparam int WORD_W      = 16;
   localparam int OPCODE_W    = 4;
   localparam int REG_IDX_W   = 4;    // rd, rs, rt and branch condition
   localparam int ARITH_IMM_W = 4;
   localparam int LS_IMM_W    = 8;    // Absolute load/save address
   localparam int CALL_W      = 12;   // Call target

   // Field LSB positions inside the instruction word
   localparam int OPCODE_LSB  = 12;
   localparam int RD_LSB      = 8;    // Shared with branch condition
   localparam int RS_LSB      = 4;
   localparam int RT_LSB      = 0;    // Shared with arith immediate
   localparam int IMM_LSB     = 0;    // Load/save imm and call target

   typedef logic [WORD_W-1:0]      word_t;
   typedef logic [ARITH_IMM_W-1:0] arith_imm_t;
   typedef logic [LS_IMM_W-1:0]    ls_imm_t;
   typedef logic [CALL_W-1:0]      call_target_t;

   typedef enum logic [OPCODE_W-1:0] {
      OP_ADD    = 4'h0,   // rd = rs + rt
      OP_SUB    = 4'h1,
      OP_AND    = 4'h2,
      OP_OR     = 4'h3,
      OP_ADDI   = 4'h4,   // rd = rs + imm4
      OP_LOAD   = 4'h8,   // rd = mem[imm8]
      OP_SAVE   = 4'h9,   // mem[imm8] = reg[11:8]
      OP_BRANCH = 4'hC,   // Condition in bits 11:8
      OP_CALL   = 4'hD,
      OP_NOP    = 4'hF
   } opcode_t;

   // Bubble word loaded on flush and reset
   localparam word_t NO_OP_WORD = 16'hF000;

endpackage

// File: common/cpu_pipe_pkg.sv
// Pipeline-side types; register index width follows the ISA register field
package cpu_pipe_pkg;

   typedef logic [cpu_isa_pkg::REG_IDX_W-1:0] reg_idx_t;

   // Register file depth, one entry per index value
   localparam int NUM_REGS = 2 ** cpu_isa_pkg::REG_IDX_W;

   // Decoded control record for the instruction in decode
   typedef struct packed {
      cpu_isa_pkg::opcode_t opcode;
      logic                 reads_rs;
      logic                 reads_rt;
      logic                 reads_rd;    // SAVE source in bits 11:8
      logic                 writes_rd;
      logic                 is_load;
   } ctrl_t;

   // Nothing read, nothing written
   localparam ctrl_t CTRL_NOP = '{
      opcode:    cpu_isa_pkg::OP_NOP,
      reads_rs:  1'b0,
      reads_rt:  1'b0,
      reads_rd:  1'b0,
      writes_rd: 1'b0,
      is_load:   1'b0
   };

endpackage

// File: common/cpu_ifs.sv
// IF/ID field bus and register-file read bus; reads on rf_read_if are combinational
`timescale 1ns/1ps

// Split instruction fields held by the IF/ID register
interface ifid_if;
   cpu_isa_pkg::word_t        pc;
   cpu_isa_pkg::opcode_t      opcode;
   cpu_pipe_pkg::reg_idx_t    cond_rd;      // rd or branch condition
   cpu_pipe_pkg::reg_idx_t    rs;
   cpu_pipe_pkg::reg_idx_t    rt;
   cpu_isa_pkg::arith_imm_t   arith_imm;
   cpu_isa_pkg::ls_imm_t      ls_imm;
   cpu_isa_pkg::call_target_t call_target;

   modport stage (output pc, opcode, cond_rd, rs, rt, arith_imm, ls_imm, call_target);
   modport dec   (input  pc, opcode, cond_rd, rs, rt, arith_imm, ls_imm, call_target);
endinterface

// Two read ports, addresses from decode, data back from the register file
interface rf_read_if;
   cpu_pipe_pkg::reg_idx_t rs_addr;
   cpu_pipe_pkg::reg_idx_t rt_addr;
   cpu_isa_pkg::word_t     rs_data;
   cpu_isa_pkg::word_t     rt_data;

   modport dec (output rs_addr, rt_addr, input  rs_data, rt_data);
   modport rf  (input  rs_addr, rt_addr, output rs_data, rt_data);
endinterface

// File: frontend/fetch_unit.sv
// Word-addressed PC, no bounds check; stall outranks redirect, PC wraps at FFFF
`timescale 1ns/1ps

module fetch_unit #(
   parameter cpu_isa_pkg::word_t RESET_PC = 16'h0000
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               stall,         // Load-use hold from decode
   input  logic               redirect,      // CALL taken in decode
   input  cpu_isa_pkg::word_t redirect_pc,
   output cpu_isa_pkg::word_t pc             // Straight to imem address
);

   cpu_isa_pkg::word_t next_pc;

   // Next PC select
   always_comb begin
      if (stall) begin
         next_pc = pc;                       // Hold, same word fetched again
      end else if (redirect) begin
         next_pc = redirect_pc;              // Jump to call target
      end else begin
         next_pc = pc + 16'd1;               // Sequential, one word per instr
      end
   end

   // PC register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= RESET_PC;
      end else begin
         pc <= next_pc;
      end
   end

endmodule

// File: frontend/ifid_reg.sv
// IF/ID register; reset and flush load NOP fields with PC 0000, hazard holds and beats flush
`timescale 1ns/1ps

module ifid_reg (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               hazard,        // Hold everything
   input  logic               flush,         // Squash the word just fetched
   input  cpu_isa_pkg::word_t pc_in,
   input  cpu_isa_pkg::word_t instruction,  // From instruction memory
   ifid_if.stage              stage
);

   logic               clear;
   logic               load_en;
   cpu_isa_pkg::word_t next_word;
   cpu_isa_pkg::word_t next_pc;

   // Reset always loads, otherwise capture only when not held
   assign clear   = !rst_n || flush;
   assign load_en = !rst_n || !hazard;

   // Bubble in place of the fetched word on flush or reset
   assign next_word = clear ? cpu_isa_pkg::NO_OP_WORD : instruction;
   assign next_pc   = clear ? '0 : pc_in;

   // Split the word into its fields as it is captured
   always_ff @(posedge clk) begin
      if (load_en) begin
         stage.pc          <= next_pc;
         stage.opcode      <= cpu_isa_pkg::opcode_t'(
            next_word[cpu_isa_pkg::OPCODE_LSB +: cpu_isa_pkg::OPCODE_W]);
         stage.cond_rd     <= next_word[cpu_isa_pkg::RD_LSB +: cpu_isa_pkg::REG_IDX_W];
         stage.rs          <= next_word[cpu_isa_pkg::RS_LSB +: cpu_isa_pkg::REG_IDX_W];
         stage.rt          <= next_word[cpu_isa_pkg::RT_LSB +: cpu_isa_pkg::REG_IDX_W];
         // Immediates overlap the register fields
         stage.arith_imm   <= next_word[cpu_isa_pkg::RT_LSB +: cpu_isa_pkg::ARITH_IMM_W];
         stage.ls_imm      <= next_word[cpu_isa_pkg::IMM_LSB +: cpu_isa_pkg::LS_IMM_W];
         stage.call_target <= next_word[cpu_isa_pkg::IMM_LSB +: cpu_isa_pkg::CALL_W];
      end
   end

endmodule

// File: frontend/decode_unit.sv
// Decode and ID/EX stage; one bubble per load-use pair, branches pass through undecided
`timescale 1ns/1ps

module decode_unit (
   input  logic                            clk,
   input  logic                            rst_n,
   ifid_if.dec                             dec,
   rf_read_if.dec                          rf,
   output logic                            stall,        // Hold PC and IF/ID
   output logic                            redirect,     // CALL, also flushes IF/ID
   output cpu_isa_pkg::word_t              redirect_pc,
   output logic                            ex_valid,
   output cpu_isa_pkg::opcode_t            ex_opcode,
   output cpu_pipe_pkg::reg_idx_t          ex_rd,
   output logic [cpu_isa_pkg::REG_IDX_W-1:0] ex_cond,
   output cpu_isa_pkg::word_t              ex_rs_data,
   output cpu_isa_pkg::word_t              ex_rt_data,
   output cpu_isa_pkg::word_t              ex_imm,
   output cpu_isa_pkg::word_t              ex_pc
);

   cpu_pipe_pkg::ctrl_t ctrl;
   logic                id_valid;          // Real instruction in decode
   logic                ex_is_load;        // ID/EX holds a LOAD
   cpu_isa_pkg::word_t  id_imm;
   logic                rs_hit;
   logic                rt_hit;
   logic                rd_hit;

   // Control decode, unassigned opcodes fall out as NOP
   always_comb begin
      ctrl        = cpu_pipe_pkg::CTRL_NOP;
      ctrl.opcode = dec.opcode;
      id_valid    = 1'b1;
      case (dec.opcode)
         cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB,
         cpu_isa_pkg::OP_AND, cpu_isa_pkg::OP_OR: begin
            ctrl.reads_rs  = 1'b1;
            ctrl.reads_rt  = 1'b1;
            ctrl.writes_rd = 1'b1;
         end
         cpu_isa_pkg::OP_ADDI: begin
            ctrl.reads_rs  = 1'b1;
            ctrl.writes_rd = 1'b1;
         end
         cpu_isa_pkg::OP_LOAD: begin
            ctrl.writes_rd = 1'b1;
            ctrl.is_load   = 1'b1;
         end
         cpu_isa_pkg::OP_SAVE:   ctrl.reads_rd = 1'b1;    // Source via rt port
         cpu_isa_pkg::OP_BRANCH: id_valid = 1'b1;         // No register use
         cpu_isa_pkg::OP_CALL:   id_valid = 1'b1;
         default:                id_valid = 1'b0;         // NOP and unassigned
      endcase
   end

   // Immediate select, all zero-extended
   always_comb begin
      case (dec.opcode)
         cpu_isa_pkg::OP_ADDI: id_imm = cpu_isa_pkg::word_t'(dec.arith_imm);
         cpu_isa_pkg::OP_LOAD,
         cpu_isa_pkg::OP_SAVE: id_imm = cpu_isa_pkg::word_t'(dec.ls_imm);
         cpu_isa_pkg::OP_CALL: id_imm = cpu_isa_pkg::word_t'(dec.call_target);
         default:              id_imm = '0;
      endcase
   end

   // Register file reads
   assign rf.rs_addr = dec.rs;
   assign rf.rt_addr = ctrl.reads_rd ? dec.cond_rd : dec.rt;

   // Load-use check against the LOAD now in ID/EX
   assign rs_hit = ctrl.reads_rs && (dec.rs == ex_rd);
   assign rt_hit = ctrl.reads_rt && (dec.rt == ex_rd);
   assign rd_hit = ctrl.reads_rd && (dec.cond_rd == ex_rd);
   assign stall  = ex_valid && ex_is_load && (rs_hit || rt_hit || rd_hit);

   // CALL redirect, one cycle since IF/ID is flushed behind it
   assign redirect    = (dec.opcode == cpu_isa_pkg::OP_CALL) && !stall;
   assign redirect_pc = cpu_isa_pkg::word_t'(dec.call_target);

   // ID/EX control, bubble on stall
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid   <= 1'b0;
         ex_is_load <= 1'b0;
      end else begin
         ex_valid   <= id_valid && !stall;
         ex_is_load <= ctrl.is_load && !stall;
      end
   end

   // ID/EX payload, fields not used by the opcode read as zero
   always_ff @(posedge clk) begin
      ex_opcode  <= ctrl.opcode;
      ex_rd      <= (ctrl.writes_rd || ctrl.reads_rd) ? dec.cond_rd : '0;
      ex_cond    <= (ctrl.opcode == cpu_isa_pkg::OP_BRANCH) ? dec.cond_rd : '0;
      ex_rs_data <= ctrl.reads_rs ? rf.rs_data : '0;
      ex_rt_data <= (ctrl.reads_rt || ctrl.reads_rd) ? rf.rt_data : '0;
      ex_imm     <= id_imm;
      ex_pc      <= dec.pc;
   end

endmodule

// File: verilog/reg_file.sv
// 16 x 16-bit registers, no reset so contents are undefined until written; write-first reads
`timescale 1ns/1ps

module reg_file (
   input  logic                   clk,
   input  logic                   wb_en,      // Write-back from the missing back end
   input  cpu_pipe_pkg::reg_idx_t wb_addr,
   input  cpu_isa_pkg::word_t     wb_data,
   rf_read_if.rf                  rd
);

   cpu_isa_pkg::word_t regs [cpu_pipe_pkg::NUM_REGS];

   // Read with bypass of a write landing this same cycle
   function automatic cpu_isa_pkg::word_t read_port(
      input cpu_pipe_pkg::reg_idx_t addr
   );
      if (wb_en && (wb_addr == addr)) begin
         return wb_data;                 // Forward new value
      end
      return regs[addr];
   endfunction

   // Single write port
   always_ff @(posedge clk) begin
      if (wb_en) begin
         regs[wb_addr] <= wb_data;
      end
   end

   // Combinational reads
   always_comb begin
      rd.rs_data = read_port(rd.rs_addr);
      rd.rt_data = read_port(rd.rt_addr);
   end

endmodule

// File: verilog/cpu_frontend.sv
// Front end only: no execute, data memory or interrupts; writes come in on the wb ports
`timescale 1ns/1ps

module cpu_frontend #(
   parameter cpu_isa_pkg::word_t RESET_PC = 16'h0000
) (
   input  logic                              clk,
   input  logic                              rst_n,
   output cpu_isa_pkg::word_t                imem_addr,   // Word address, PC register
   input  cpu_isa_pkg::word_t                imem_data,   // Sampled at next edge
   input  logic                              wb_en,
   input  cpu_pipe_pkg::reg_idx_t            wb_addr,
   input  cpu_isa_pkg::word_t                wb_data,
   output logic                              ex_valid,
   output cpu_isa_pkg::opcode_t              ex_opcode,
   output cpu_pipe_pkg::reg_idx_t            ex_rd,
   output logic [cpu_isa_pkg::REG_IDX_W-1:0] ex_cond,
   output cpu_isa_pkg::word_t                ex_rs_data,
   output cpu_isa_pkg::word_t                ex_rt_data,
   output cpu_isa_pkg::word_t                ex_imm,
   output cpu_isa_pkg::word_t                ex_pc
);

   logic               stall;
   logic               redirect;
   cpu_isa_pkg::word_t redirect_pc;

   ifid_if    ifid_bus ();
   rf_read_if rf_bus ();

   fetch_unit #(
      .RESET_PC (RESET_PC)
   ) fetch_unit_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .pc          (imem_addr)
   );

   // Redirect doubles as flush
   ifid_reg ifid_reg_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .hazard      (stall),
      .flush       (redirect),
      .pc_in       (imem_addr),
      .instruction (imem_data),
      .stage       (ifid_bus.stage)
   );

   decode_unit decode_unit_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .dec         (ifid_bus.dec),
      .rf          (rf_bus.dec),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .ex_valid    (ex_valid),
      .ex_opcode   (ex_opcode),
      .ex_rd       (ex_rd),
      .ex_cond     (ex_cond),
      .ex_rs_data  (ex_rs_data),
      .ex_rt_data  (ex_rt_data),
      .ex_imm      (ex_imm),
      .ex_pc       (ex_pc)
   );

   reg_file reg_file_inst (
      .clk     (clk),
      .wb_en   (wb_en),
      .wb_addr (wb_addr),
      .wb_data (wb_data),
      .rd      (rf_bus.rf)
   );

endmodule

// File: sim/tb_cpu_frontend.sv
// Runs with RESET_PC 0000; program starts at 0012 so its reads follow the 16-cycle register preload
`timescale 1ns/1ps

module tb_cpu_frontend;

   localparam logic [15:0] RESET_PC       = 16'h0000;
   localparam int          RESET_CYCLES   = 16;
   localparam int          NUM_REGS       = 16;
   localparam int          NUM_PROG       = 17;
   localparam int          NUM_EXP        = 14;
   localparam int          DRAIN_CYCLES   = 4;      // Extra cycles in which nothing may show valid
   localparam int          TIMEOUT_CYCLES = RESET_CYCLES + NUM_REGS + 3 * NUM_PROG + 20;
   localparam logic [31:0] SEED           = 32'hcf904e50;
   localparam logic [4:0]  NO_READ        = 5'h10;  // Bit 4 marks an operand read as zero
   localparam logic [15:0] BYPASS_ADDR    = 16'h001C; // ADDI r9, r4, #2
   localparam logic [3:0]  BYPASS_REG     = 4'h4;

   logic                   clk;
   logic                   rst_n;
   logic [15:0]            imem_addr;
   logic [15:0]            imem_data;
   logic                   wb_en;
   logic [3:0]             wb_addr;
   logic [15:0]            wb_data;
   logic                   ex_valid;
   cpu_isa_pkg::opcode_t   ex_opcode;
   logic [3:0]             ex_rd;
   logic [3:0]             ex_cond;
   logic [15:0]            ex_rs_data;
   logic [15:0]            ex_rt_data;
   logic [15:0]            ex_imm;
   logic [15:0]            ex_pc;

   // Instruction memory contents
   logic [15:0] prog_addr [NUM_PROG];
   logic [15:0] prog_word [NUM_PROG];
   int          prog_count;

   // Expected ex stream in order
   logic [15:0] exp_pc     [NUM_EXP];
   logic [3:0]  exp_opcode [NUM_EXP];
   logic [3:0]  exp_rd     [NUM_EXP];
   logic [3:0]  exp_cond   [NUM_EXP];
   logic [15:0] exp_imm    [NUM_EXP];
   logic [4:0]  exp_rs     [NUM_EXP];      // Register index or NO_READ
   logic [4:0]  exp_rt     [NUM_EXP];
   logic [15:0] exp_gap    [NUM_EXP];      // Cycles since previous valid entry or first fetch
   int          exp_count;
   int          exp_idx;

   logic [15:0] shadow [NUM_REGS];        // Mirror of the register file
   logic [31:0] rng_state;
   int          cycle_count;
   int          last_valid_cycle;
   logic [15:0] prev_addr;                // imem_addr seen at the previous falling edge
   logic        bypass_done;

   cpu_frontend #(
      .RESET_PC (RESET_PC)
   ) cpu_frontend_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .imem_addr  (imem_addr),
      .imem_data  (imem_data),
      .wb_en      (wb_en),
      .wb_addr    (wb_addr),
      .wb_data    (wb_data),
      .ex_valid   (ex_valid),
      .ex_opcode  (ex_opcode),
      .ex_rd      (ex_rd),
      .ex_cond    (ex_cond),
      .ex_rs_data (ex_rs_data),
      .ex_rt_data (ex_rt_data),
      .ex_imm     (ex_imm),
      .ex_pc      (ex_pc)
   );

   // 40 ns period
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [15:0] next_random_word();
      rng_state = xorshift32(rng_state);
      return rng_state[15:0];                  // Low half as register value
   endfunction

   // Memory model where unlisted words read as NOP
   function automatic logic [15:0] fetch_word(input logic [15:0] addr);
      logic [15:0] word;
      int          i;
      word = cpu_isa_pkg::NO_OP_WORD;
      for (i = 0; i < NUM_PROG; i++) begin
         if (prog_addr[i] == addr) begin
            word = prog_word[i];
         end
      end
      return word;
   endfunction

   function automatic logic [15:0] expected_data(input logic [4:0] sel);
      if (sel[4]) begin
         return 16'h0000;                      // Operand not read
      end
      return shadow[sel[3:0]];
   endfunction

   task automatic add_program(input logic [15:0] addr, input logic [15:0] word);
      prog_addr[prog_count] = addr;
      prog_word[prog_count] = word;
      prog_count++;
   endtask

   task automatic add_expected(input logic [15:0] pc, input logic [3:0] opcode,
                               input logic [3:0] rd, input logic [3:0] cond,
                               input logic [15:0] imm, input logic [4:0] rs,
                               input logic [4:0] rt, input logic [15:0] gap);
      exp_pc[exp_count]     = pc;
      exp_opcode[exp_count] = opcode;
      exp_rd[exp_count]     = rd;
      exp_cond[exp_count]   = cond;
      exp_imm[exp_count]    = imm;
      exp_rs[exp_count]     = rs;
      exp_rt[exp_count]     = rt;
      exp_gap[exp_count]    = gap;
      exp_count++;
   endtask

   task automatic load_tables();
      add_program(16'h0012, 16'h0123);         // ADD  r1, r2, r3
      add_program(16'h0013, 16'h1456);         // SUB  r4, r5, r6
      add_program(16'h0014, 16'h2789);         // AND  r7, r8, r9
      add_program(16'h0015, 16'h3ABC);         // OR   rA, rB, rC
      add_program(16'h0016, 16'h4DEF);         // ADDI rD, rE, #F
      add_program(16'h0017, 16'hF000);         // NOP
      add_program(16'h0018, 16'h953C);         // SAVE r5, #3C
      add_program(16'h0019, 16'hC7FF);         // BRANCH cond 7
      add_program(16'h001A, 16'h8681);         // LOAD r6, #81
      add_program(16'h001B, 16'h0261);         // ADD r2, r6, r1 right after the load
      add_program(16'h001C, 16'h4942);         // ADDI r9, r4, #2 reads r4 on bypass
      add_program(16'h001D, 16'hD040);         // CALL 040
      add_program(16'h001E, 16'h0333);         // Squashed by the call
      add_program(16'h0040, 16'h30F8);         // OR   r0, rF, r8
      add_program(16'h0041, 16'h9AFE);         // SAVE rA, #FE
      add_program(16'h0042, 16'hFFFF);         // NOP
      add_program(16'h0043, 16'hC2AB);         // BRANCH cond 2

      // pc, opcode, rd, cond, imm, rs, rt, gap
      add_expected(16'h0012, 4'h0, 4'h1, 4'h0, 16'h0000, 5'h02, 5'h03, 16'd2);  // Fetch latency
      add_expected(16'h0013, 4'h1, 4'h4, 4'h0, 16'h0000, 5'h05, 5'h06, 16'd1);
      add_expected(16'h0014, 4'h2, 4'h7, 4'h0, 16'h0000, 5'h08, 5'h09, 16'd1);
      add_expected(16'h0015, 4'h3, 4'hA, 4'h0, 16'h0000, 5'h0B, 5'h0C, 16'd1);
      add_expected(16'h0016, 4'h4, 4'hD, 4'h0, 16'h000F, 5'h0E, NO_READ, 16'd1);
      add_expected(16'h0018, 4'h9, 4'h5, 4'h0, 16'h003C, NO_READ, 5'h05, 16'd2);  // NOP gap
      add_expected(16'h0019, 4'hC, 4'h0, 4'h7, 16'h0000, NO_READ, NO_READ, 16'd1);
      add_expected(16'h001A, 4'h8, 4'h6, 4'h0, 16'h0081, NO_READ, NO_READ, 16'd1);
      add_expected(16'h001B, 4'h0, 4'h2, 4'h0, 16'h0000, 5'h06, 5'h01, 16'd2);  // One bubble
      add_expected(16'h001C, 4'h4, 4'h9, 4'h0, 16'h0002, 5'h04, NO_READ, 16'd1);
      add_expected(16'h001D, 4'hD, 4'h0, 4'h0, 16'h0040, NO_READ, NO_READ, 16'd1);
      add_expected(16'h0040, 4'h3, 4'h0, 4'h0, 16'h0000, 5'h0F, 5'h08, 16'd2);  // Flush gap
      add_expected(16'h0041, 4'h9, 4'hA, 4'h0, 16'h00FE, NO_READ, 5'h0A, 16'd1);
      add_expected(16'h0043, 4'hC, 4'h0, 4'h2, 16'h0000, NO_READ, NO_READ, 16'd2);
   endtask

   task automatic abort_run();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] %s: got %h, expected %h (entry %0d, cycle %0d)",
                  name, actual, expected, exp_idx, cycle_count);
         abort_run();
      end
   endtask

   task automatic write_register(input logic [3:0] idx, input logic [15:0] value);
      wb_en   = 1'b1;
      wb_addr = idx;
      wb_data = value;
      shadow[idx] = value;                     // Lands at the next rising edge
   endtask

   // Every valid ex cycle consumes one expected entry
   task automatic compare_ex_outputs();
      if (ex_valid === 1'b1) begin
         if (exp_idx >= NUM_EXP) begin
            $display("ex_valid high with no expected instruction left at cycle %0d",
                     cycle_count);
            abort_run();
         end else begin
            check_value("ex_pc", ex_pc, exp_pc[exp_idx]);      // Checked first to show order errors
            check_value("ex_opcode", 16'(ex_opcode), 16'(exp_opcode[exp_idx]));
            check_value("ex_rd", 16'(ex_rd), 16'(exp_rd[exp_idx]));
            check_value("ex_cond", 16'(ex_cond), 16'(exp_cond[exp_idx]));
            check_value("ex_imm", ex_imm, exp_imm[exp_idx]);
            check_value("ex_rs_data", ex_rs_data, expected_data(exp_rs[exp_idx]));
            check_value("ex_rt_data", ex_rt_data, expected_data(exp_rt[exp_idx]));
            check_value("ex_valid gap", 16'(cycle_count - last_valid_cycle),
                        exp_gap[exp_idx]);
            last_valid_cycle = cycle_count;
            exp_idx++;
         end
      end
   endtask

   // Sample outputs then drive inputs at one falling edge
   task automatic advance_cycle();
      @(negedge clk);
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles with %0d of %0d expected instructions seen",
                  cycle_count, exp_idx, NUM_EXP);
         abort_run();
      end
      compare_ex_outputs();
      // Latency of the first entry counts from its fetch
      if (exp_idx == 0 && imem_addr == exp_pc[0]) begin
         last_valid_cycle = cycle_count;
      end
      imem_data = fetch_word(imem_addr);
      wb_en     = 1'b0;
      // Fetch has left the ADDI so it sits in decode this cycle
      if (!bypass_done && prev_addr == BYPASS_ADDR && imem_addr != BYPASS_ADDR) begin
         write_register(BYPASS_REG, next_random_word());
         bypass_done = 1'b1;
      end
      prev_addr = imem_addr;
   endtask

   initial begin
      int i;
      rst_n            = 1'b0;
      imem_data        = cpu_isa_pkg::NO_OP_WORD;
      wb_en            = 1'b0;
      wb_addr          = 4'h0;
      wb_data          = 16'h0000;
      rng_state        = SEED;
      cycle_count      = 0;
      last_valid_cycle = 0;
      exp_idx          = 0;
      prog_count       = 0;
      exp_count        = 0;
      prev_addr        = RESET_PC;
      bypass_done      = 1'b0;
      load_tables();

      repeat (RESET_CYCLES) advance_cycle();
      check_value("imem_addr", imem_addr, RESET_PC);   // Still in reset here
      check_value("ex_valid", 16'(ex_valid), 16'h0000);
      rst_n = 1'b1;

      // Preload while the PC runs through NOPs
      for (i = 0; i < NUM_REGS; i++) begin
         advance_cycle();
         write_register(4'(i), next_random_word());
      end

      while (exp_idx < NUM_EXP) advance_cycle();
      repeat (DRAIN_CYCLES) advance_cycle();

      if (exp_idx == NUM_EXP && bypass_done) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("Run ended with %0d of %0d expected instructions, bypass write issued %0d",
                  exp_idx, NUM_EXP, bypass_done);
         abort_run();
      end
   end

endmodule

// File: project.f
common/cpu_isa_pkg.sv
common/cpu_pipe_pkg.sv
common/cpu_ifs.sv
frontend/fetch_unit.sv
frontend/ifid_reg.sv
frontend/decode_unit.sv
verilog/reg_file.sv
verilog/cpu_frontend.sv
sim/tb_cpu_frontend.sv

// File: build.sh
#!/bin/sh
# Compile the front end and its testbench with Verilator, run it, and judge by the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/1ps --top-module tb_cpu_frontend -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_cpu_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test passed" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
